// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int WORD_W = 32;
    localparam int REG_COUNT = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
    typedef logic [5:0] opcode_t;

    // lsb positions of the instruction word fields
    localparam int OPC_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_LSB = 0;
    localparam int SHAMT_W = 5;
    localparam int IMM_W = 16;

    // I-type forms share the R-type members of the decoded operation
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // major opcodes
    localparam opcode_t OPC_SPECIAL = 6'h00;
    localparam opcode_t OPC_ADDIU = 6'h09;
    localparam opcode_t OPC_SLTI = 6'h0a;
    localparam opcode_t OPC_ANDI = 6'h0c;
    localparam opcode_t OPC_ORI = 6'h0d;
    localparam opcode_t OPC_XORI = 6'h0e;
    localparam opcode_t OPC_LUI = 6'h0f;

    // function codes of the SPECIAL group
    localparam opcode_t FN_SLL = 6'h00;
    localparam opcode_t FN_SRL = 6'h02;
    localparam opcode_t FN_ADDU = 6'h21;
    localparam opcode_t FN_SUBU = 6'h23;
    localparam opcode_t FN_AND = 6'h24;
    localparam opcode_t FN_OR = 6'h25;
    localparam opcode_t FN_XOR = 6'h26;
    localparam opcode_t FN_NOR = 6'h27;
    localparam opcode_t FN_SLT = 6'h2a;
    localparam opcode_t FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

// ==== hw/fetch/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000,
    parameter int QUEUE_DEPTH = 4,
    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1
) (
    input  wire logic             clk_i,
    input  wire logic             arst_n_i,

    input  wire logic [CNT_W-1:0] queue_count_i,

    input  wire logic             wb_ack_i,
    input  wire core_pkg::word_t  wb_dat_i,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output core_pkg::word_t       wb_adr_o,

    output logic                  push_o,
    output core_pkg::word_t       push_data_o
);

    logic            bus_active;
    core_pkg::word_t pc;
    logic            queue_has_room;

    // count already includes a word pushed at the last ack
    assign queue_has_room = queue_count_i < CNT_W'(QUEUE_DEPTH);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus_active <= 1'b0;
            pc <= RESET_PC;
        end else if (bus_active) begin
            // cycle closes on ack and one idle cycle follows
            if (wb_ack_i) begin
                bus_active <= 1'b0;
                pc <= pc + 32'd4;
            end
        end else if (queue_has_room) begin
            bus_active <= 1'b1;
        end
    end

    // cyc and stb always move together in a classic read
    assign wb_cyc_o = bus_active;
    assign wb_stb_o = bus_active;
    assign wb_adr_o = pc;

    // acked word goes straight into the queue
    assign push_o = bus_active & wb_ack_i;
    assign push_data_o = wb_dat_i;

    // request held with a stable address until the slave acks
    a_wb_hold: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        wb_stb_o && !wb_ack_i |=> wb_cyc_o && wb_stb_o && $stable(wb_adr_o)
    ) else $error("wb request dropped or address changed before ack");

endmodule

`default_nettype wire

// ==== hw/fetch/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_queue #(
    parameter int QUEUE_DEPTH = 4,
    localparam int PTR_W = $clog2(QUEUE_DEPTH),
    localparam int CNT_W = PTR_W + 1
) (
    input  wire logic             clk_i,
    input  wire logic             arst_n_i,

    input  wire logic             push_i,
    input  wire core_pkg::word_t  push_data_i,

    input  wire logic             pop_i,
    output core_pkg::word_t       head_o,
    output logic                  empty_o,
    output logic [CNT_W-1:0]      count_o
);

    core_pkg::word_t  mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_o = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign count_o = count;

    // fetch only requests with room left, so a push never meets a full queue
    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        push_i |-> count < CNT_W'(QUEUE_DEPTH)
    ) else $error("push into full instruction queue");

    // the consumer must respect empty
    a_no_underflow: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> !empty_o
    ) else $error("pop from empty instruction queue");

endmodule

`default_nettype wire

// ==== hw/execute/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,

    input  wire core_pkg::reg_addr_t raddr_a_i,
    input  wire core_pkg::reg_addr_t raddr_b_i,
    output core_pkg::word_t          rdata_a_o,
    output core_pkg::word_t          rdata_b_o,

    input  wire logic                we_i,
    input  wire core_pkg::reg_addr_t waddr_i,
    input  wire core_pkg::word_t     wdata_i
);

    // r0 has no storage
    core_pkg::word_t regs [1:core_pkg::REG_COUNT-1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads without a write bypass
    // the execute stage forwards the value being written
    always_comb begin
        if (raddr_a_i == '0) begin
            rdata_a_o = '0;
        end else begin
            rdata_a_o = regs[raddr_a_i];
        end
    end

    always_comb begin
        if (raddr_b_i == '0) begin
            rdata_b_o = '0;
        end else begin
            rdata_b_o = regs[raddr_b_i];
        end
    end

endmodule

`default_nettype wire

// ==== hw/execute/exec_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire logic                stall_i,

    input  wire core_pkg::word_t     inst_i,
    input  wire logic                empty_i,
    output logic                     pop_o,

    output core_pkg::reg_addr_t      raddr_a_o,
    output core_pkg::reg_addr_t      raddr_b_o,
    input  wire core_pkg::word_t     rdata_a_i,
    input  wire core_pkg::word_t     rdata_b_i,

    output logic                     retire_we_o,
    output core_pkg::reg_addr_t      retire_addr_o,
    output core_pkg::word_t          retire_data_o
);

    localparam int REG_W = $bits(core_pkg::reg_addr_t);
    localparam int IMM_W = core_pkg::IMM_W;
    localparam int EXT_W = core_pkg::WORD_W - IMM_W;

    core_pkg::opcode_t          opcode;
    core_pkg::opcode_t          funct;
    core_pkg::reg_addr_t        rs;
    core_pkg::reg_addr_t        rt;
    core_pkg::reg_addr_t        rd;
    logic [core_pkg::SHAMT_W-1:0] shamt;
    logic [IMM_W-1:0]           imm;

    core_pkg::alu_op_e          alu_op;
    core_pkg::reg_addr_t        dest;
    logic                       use_imm;
    logic                       imm_signed;
    core_pkg::word_t            imm_ext;
    core_pkg::word_t            op_a;
    core_pkg::word_t            src_b;
    core_pkg::word_t            op_b;
    core_pkg::word_t            result;
    logic                       retire_en;

    // instruction fields
    assign opcode = inst_i[core_pkg::OPC_LSB +: 6];
    assign funct = inst_i[core_pkg::FUNCT_LSB +: 6];
    assign rs = inst_i[core_pkg::RS_LSB +: REG_W];
    assign rt = inst_i[core_pkg::RT_LSB +: REG_W];
    assign rd = inst_i[core_pkg::RD_LSB +: REG_W];
    assign shamt = inst_i[core_pkg::SHAMT_LSB +: core_pkg::SHAMT_W];
    assign imm = inst_i[core_pkg::IMM_LSB +: IMM_W];

    always_comb begin
        alu_op = core_pkg::ALU_NOP;
        case (opcode)
            core_pkg::OPC_SPECIAL: begin
                case (funct)
                    core_pkg::FN_ADDU: alu_op = core_pkg::ALU_ADDU;
                    core_pkg::FN_SUBU: alu_op = core_pkg::ALU_SUBU;
                    core_pkg::FN_AND: alu_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR: alu_op = core_pkg::ALU_OR;
                    core_pkg::FN_XOR: alu_op = core_pkg::ALU_XOR;
                    core_pkg::FN_NOR: alu_op = core_pkg::ALU_NOR;
                    core_pkg::FN_SLT: alu_op = core_pkg::ALU_SLT;
                    core_pkg::FN_SLTU: alu_op = core_pkg::ALU_SLTU;
                    core_pkg::FN_SLL: alu_op = core_pkg::ALU_SLL;
                    core_pkg::FN_SRL: alu_op = core_pkg::ALU_SRL;
                    default: alu_op = core_pkg::ALU_NOP;
                endcase
            end
            core_pkg::OPC_ADDIU: alu_op = core_pkg::ALU_ADDU;
            core_pkg::OPC_SLTI: alu_op = core_pkg::ALU_SLT;
            core_pkg::OPC_ANDI: alu_op = core_pkg::ALU_AND;
            core_pkg::OPC_ORI: alu_op = core_pkg::ALU_OR;
            core_pkg::OPC_XORI: alu_op = core_pkg::ALU_XOR;
            core_pkg::OPC_LUI: alu_op = core_pkg::ALU_LUI;
            default: alu_op = core_pkg::ALU_NOP;
        endcase
    end

    // I-type writes rt, arithmetic forms sign extend, logic forms zero extend
    assign use_imm = (opcode != core_pkg::OPC_SPECIAL);
    assign dest = use_imm ? rt : rd;
    assign imm_signed = (opcode == core_pkg::OPC_ADDIU) || (opcode == core_pkg::OPC_SLTI);
    assign imm_ext = imm_signed ? {{EXT_W{imm[IMM_W-1]}}, imm} : {{EXT_W{1'b0}}, imm};

    // writeback value bypasses the not yet written register
    assign raddr_a_o = rs;
    assign raddr_b_o = rt;
    assign op_a = (retire_we_o && retire_addr_o == rs) ? retire_data_o : rdata_a_i;
    assign src_b = (retire_we_o && retire_addr_o == rt) ? retire_data_o : rdata_b_i;
    assign op_b = use_imm ? imm_ext : src_b;

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADDU: result = op_a + op_b;
            core_pkg::ALU_SUBU: result = op_a - op_b;
            core_pkg::ALU_AND: result = op_a & op_b;
            core_pkg::ALU_OR: result = op_a | op_b;
            core_pkg::ALU_XOR: result = op_a ^ op_b;
            core_pkg::ALU_NOR: result = ~(op_a | op_b);
            core_pkg::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU: result = {31'b0, op_a < op_b};
            // shifts act on rt by shamt
            core_pkg::ALU_SLL: result = op_b << shamt;
            core_pkg::ALU_SRL: result = op_b >> shamt;
            core_pkg::ALU_LUI: result = {imm, {EXT_W{1'b0}}};
            default: result = '0;
        endcase
    end

    assign pop_o = !empty_i && !stall_i;
    assign retire_en = pop_o && (alu_op != core_pkg::ALU_NOP) && (dest != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_we_o <= 1'b0;
        end else begin
            retire_we_o <= retire_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (retire_en) begin
            retire_addr_o <= dest;
            retire_data_o <= result;
        end
    end

    a_no_r0_retire: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        retire_we_o |-> retire_addr_o != '0
    ) else $error("retire to r0");

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire logic                stall_i,

    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output core_pkg::word_t          wb_adr_o,
    input  wire core_pkg::word_t     wb_dat_i,
    input  wire logic                wb_ack_i,

    output logic                     retire_we_o,
    output core_pkg::reg_addr_t      retire_addr_o,
    output core_pkg::word_t          retire_data_o
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

    // fetch to queue
    logic                push;
    core_pkg::word_t     push_data;
    logic [CNT_W-1:0]    queue_count;

    // queue to execute
    core_pkg::word_t     queue_head;
    logic                queue_empty;
    logic                queue_pop;

    // register file read ports
    core_pkg::reg_addr_t raddr_a;
    core_pkg::reg_addr_t raddr_b;
    core_pkg::word_t     rdata_a;
    core_pkg::word_t     rdata_b;

    fetch_unit #(
        .RESET_PC(RESET_PC),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) fetch_unit_inst (
        .clk_i,
        .arst_n_i,
        .queue_count_i(queue_count),
        .wb_ack_i,
        .wb_dat_i,
        .wb_cyc_o,
        .wb_stb_o,
        .wb_adr_o,
        .push_o(push),
        .push_data_o(push_data)
    );

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) inst_queue_inst (
        .clk_i,
        .arst_n_i,
        .push_i(push),
        .push_data_i(push_data),
        .pop_i(queue_pop),
        .head_o(queue_head),
        .empty_o(queue_empty),
        .count_o(queue_count)
    );

    // writeback port is fed by the retire triple
    regfile regfile_inst (
        .clk_i,
        .arst_n_i,
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b),
        .we_i(retire_we_o),
        .waddr_i(retire_addr_o),
        .wdata_i(retire_data_o)
    );

    exec_stage exec_stage_inst (
        .clk_i,
        .arst_n_i,
        .stall_i,
        .inst_i(queue_head),
        .empty_i(queue_empty),
        .pop_o(queue_pop),
        .raddr_a_o(raddr_a),
        .raddr_b_o(raddr_b),
        .rdata_a_i(rdata_a),
        .rdata_b_i(rdata_b),
        .retire_we_o,
        .retire_addr_o,
        .retire_data_o
    );

endmodule

`default_nettype wire

// ==== verification/tb_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_core;

    localparam logic [31:0] RESET_PC = 32'hbfc0_0000;
    localparam int QUEUE_DEPTH = 4;
    localparam int PROG_LEN = 200;
    localparam int CYCLE_LIMIT = PROG_LEN * 8 + 100;
    localparam int TAIL_CYCLES = 20;

    logic        clk;
    logic        arst_n;
    logic        stall;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic        retire_we;
    logic [4:0]  retire_addr;
    logic [31:0] retire_data;

    logic [31:0] lfsr_state;
    logic [31:0] program_mem [PROG_LEN];
    logic [4:0]  exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_total;
    int          retire_count;
    int          ack_count;
    int          cycles;
    int          bus_errors;
    int          retire_errors;
    int          stall_errors;
    int          other_errors;

    // bus slave state
    logic        in_access;
    logic [31:0] held_adr;
    int          wait_left;

    core_top #(
        .RESET_PC(RESET_PC),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) core_top_inst (
        .clk_i(clk),
        .arst_n_i(arst_n),
        .stall_i(stall),
        .wb_cyc_o(wb_cyc),
        .wb_stb_o(wb_stb),
        .wb_adr_o(wb_adr),
        .wb_dat_i(wb_dat),
        .wb_ack_i(wb_ack),
        .retire_we_o(retire_we),
        .retire_addr_o(retire_addr),
        .retire_data_o(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] sh,
                                             input logic [5:0] fn);
        return {core_pkg::OPC_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] opc, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // the word 0 beyond the program is an sll to r0 and never retires
    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        logic [31:0] idx;
        idx = (adr - RESET_PC) >> 2;
        if (idx < PROG_LEN) begin
            return program_mem[idx];
        end else begin
            return 32'h0;
        end
    endfunction

    // random program and the in-order register model in one pass
    task automatic build_program();
        logic [31:0] regs [32];
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] res;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [4:0]  dst;
        logic [15:0] imm;
        logic [3:0]  kind;
        logic        known;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            known = (random_bits(4) != 32'd0);
            r = random_bits(4);
            kind = r[3:0];
            r = random_bits(3);
            rs = r[4:0];
            r = random_bits(3);
            rt = r[4:0];
            r = random_bits(3);
            rd = r[4:0];
            r = random_bits(5);
            sh = r[4:0];
            r = random_bits(16);
            imm = r[15:0];
            a = regs[rs];
            b = regs[rt];
            sext = {{16{imm[15]}}, imm};
            zext = {16'h0, imm};
            dst = (kind < 4'd10) ? rd : rt;
            case (kind)
                4'd0: res = a + b;
                4'd1: res = a - b;
                4'd2: res = a & b;
                4'd3: res = a | b;
                4'd4: res = a ^ b;
                4'd5: res = ~(a | b);
                4'd6: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                4'd7: res = (a < b) ? 32'd1 : 32'd0;
                4'd8: res = b << sh;
                4'd9: res = b >> sh;
                4'd10: res = a + sext;
                4'd11: res = a & zext;
                4'd12: res = a | zext;
                4'd13: res = a ^ zext;
                4'd14: res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                default: res = {imm, 16'h0};
            endcase
            case (kind)
                4'd0: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_ADDU);
                4'd1: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_SUBU);
                4'd2: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_AND);
                4'd3: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_OR);
                4'd4: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_XOR);
                4'd5: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_NOR);
                4'd6: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_SLT);
                4'd7: program_mem[i] = encode_r(rs, rt, rd, 5'd0, core_pkg::FN_SLTU);
                4'd8: program_mem[i] = encode_r(5'd0, rt, rd, sh, core_pkg::FN_SLL);
                4'd9: program_mem[i] = encode_r(5'd0, rt, rd, sh, core_pkg::FN_SRL);
                4'd10: program_mem[i] = encode_i(core_pkg::OPC_ADDIU, rs, rt, imm);
                4'd11: program_mem[i] = encode_i(core_pkg::OPC_ANDI, rs, rt, imm);
                4'd12: program_mem[i] = encode_i(core_pkg::OPC_ORI, rs, rt, imm);
                4'd13: program_mem[i] = encode_i(core_pkg::OPC_XORI, rs, rt, imm);
                4'd14: program_mem[i] = encode_i(core_pkg::OPC_SLTI, rs, rt, imm);
                default: program_mem[i] = encode_i(core_pkg::OPC_LUI, 5'd0, rt, imm);
            endcase
            if (!known) begin
                // major opcodes 0x20 and up are outside the kept set
                r = random_bits(31);
                program_mem[i] = {1'b1, r[30:0]};
            end else if (dst != 5'd0) begin
                regs[dst] = res;
                exp_addr_q.push_back(dst);
                exp_data_q.push_back(res);
            end
        end
        exp_total = exp_addr_q.size();
    endtask

    task automatic check_retire();
        logic [4:0]  want_addr;
        logic [31:0] want_data;
        // stall still holds the value seen at the last rising edge
        if (stall && retire_we) begin
            $display("error retire_we_o: got %h expected %h after a stalled cycle",
                     retire_we, 1'b0);
            stall_errors++;
        end
        if (retire_we) begin
            retire_count++;
            if (exp_addr_q.size() == 0) begin
                $display("unexpected retire to register %0d after the last expected result",
                         retire_addr);
                other_errors++;
            end else begin
                want_addr = exp_addr_q.pop_front();
                want_data = exp_data_q.pop_front();
                if (retire_addr !== want_addr) begin
                    $display("error retire_addr_o: got %h expected %h", retire_addr, want_addr);
                    retire_errors++;
                end
                if (retire_data !== want_data) begin
                    $display("error retire_data_o: got %h expected %h", retire_data, want_data);
                    retire_errors++;
                end
            end
        end
    endtask

    // classic read slave with 0 to 3 wait states per access
    task automatic serve_bus();
        logic [31:0] want_adr;
        logic [31:0] r;
        want_adr = RESET_PC + 32'(ack_count) * 32'd4;
        // wb_ack still holds the ack driven one cycle ago
        if (wb_ack) begin
            if (wb_cyc !== 1'b0) begin
                $display("error wb_cyc_o: got %h expected %h after ack", wb_cyc, 1'b0);
                bus_errors++;
            end
            if (wb_stb !== 1'b0) begin
                $display("error wb_stb_o: got %h expected %h after ack", wb_stb, 1'b0);
                bus_errors++;
            end
        end
        if (wb_stb === 1'b1 && wb_cyc !== 1'b1) begin
            $display("error wb_cyc_o: got %h expected %h with stb high", wb_cyc, 1'b1);
            bus_errors++;
        end
        wb_ack = 1'b0;
        if (in_access && !(wb_cyc && wb_stb)) begin
            $display("bus request at address %h dropped before its ack", held_adr);
            bus_errors++;
            in_access = 1'b0;
        end
        if (wb_cyc && wb_stb) begin
            if (!in_access) begin
                in_access = 1'b1;
                held_adr = wb_adr;
                r = random_bits(2);
                wait_left = int'(r[1:0]);
                if (wb_adr !== want_adr) begin
                    $display("error wb_adr_o: got %h expected %h", wb_adr, want_adr);
                    bus_errors++;
                end
            end else if (wb_adr !== held_adr) begin
                $display("error wb_adr_o: got %h expected %h", wb_adr, held_adr);
                bus_errors++;
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                wb_dat = fetch_word(wb_adr);
                ack_count++;
                in_access = 1'b0;
            end else begin
                wait_left--;
            end
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        cycles++;
        check_retire();
        serve_bus();
        stall = (random_bits(2) == 32'd0);
    endtask

    initial begin
        arst_n = 1'b0;
        stall = 1'b0;
        wb_ack = 1'b0;
        wb_dat = '0;
        in_access = 1'b0;
        held_adr = '0;
        wait_left = 0;
        lfsr_state = 32'he440_4ce2;
        retire_count = 0;
        ack_count = 0;
        cycles = 0;
        bus_errors = 0;
        retire_errors = 0;
        stall_errors = 0;
        other_errors = 0;
        build_program();

        // two rising edges in reset
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        while (retire_count < exp_total && cycles < CYCLE_LIMIT) begin
            run_cycle();
        end
        if (retire_count < exp_total) begin
            $display("timeout after %0d cycles with %0d of %0d results retired",
                     cycles, retire_count, exp_total);
            other_errors++;
        end else begin
            // trailing no-ops and zero words must not retire
            repeat (TAIL_CYCLES) run_cycle();
            if (retire_count != exp_total) begin
                $display("retired %0d results where the model expects %0d",
                         retire_count, exp_total);
                other_errors++;
            end
        end

        $display("retired %0d/%0d, acks %0d, errors bus %0d retire %0d stall %0d other %0d",
                 retire_count, exp_total, ack_count, bus_errors, retire_errors,
                 stall_errors, other_errors);
        if (bus_errors + retire_errors + stall_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
common/core_pkg.sv
hw/fetch/fetch_unit.sv
hw/fetch/inst_queue.sv
hw/execute/regfile.sv
hw/execute/exec_stage.sv
hw/core_top.sv
verification/tb_core.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - common/core_pkg.sv
  - hw/fetch/fetch_unit.sv
  - hw/fetch/inst_queue.sv
  - hw/execute/regfile.sv
  - hw/execute/exec_stage.sv
  - hw/core_top.sv
  - target: test
    files:
      - verification/tb_core.sv
